//--- rtl/jtag_consts.svh
// Size and clock constants of the JTAG host.
// Include wherever scan widths or the TCK divisor are needed.

`ifndef JTAG_CONSTS_SVH
`define JTAG_CONSTS_SVH

// Widest instruction and data word in bits
`define JTAG_MAX_IR_LEN 32
`define JTAG_MAX_DR_LEN 64

// clk cycles per TCK half period, minus one
`define JTAG_TCK_DIVISOR 7

`endif

//--- rtl/jtag_tap_pkg.sv
// TAP controller state encoding for the JTAG host and the target model.
// Both sides of the link step through these states on TCK rising edges.

package jtag_tap_pkg;

    // The sixteen states of the IEEE 1149.1 TAP controller
    typedef enum logic [3:0]
    {
        TAP_RESET,
        TAP_IDLE,
        TAP_SELECT_DR,
        TAP_CAPTURE_DR,
        TAP_SHIFT_DR,
        TAP_EXIT1_DR,
        TAP_PAUSE_DR,
        TAP_EXIT2_DR,
        TAP_UPDATE_DR,
        TAP_SELECT_IR,
        TAP_CAPTURE_IR,
        TAP_SHIFT_IR,
        TAP_EXIT1_IR,
        TAP_PAUSE_IR,
        TAP_EXIT2_IR,
        TAP_UPDATE_IR
    } tap_state_t;

endpackage

//--- rtl/jtag_host_pkg.sv
// Types for one JTAG scan request, held by the sequencer and read by the shifter.

`include "jtag_consts.svh"

package jtag_host_pkg;

    // Instruction length, 1 to 32 bits
    typedef logic [5:0] ir_len_t;

    // Data length, 1 to 64 bits
    typedef logic [6:0] dr_len_t;

    // One transaction: an IR scan followed by a DR scan
    typedef struct packed
    {
        ir_len_t                      ir_len;
        logic [`JTAG_MAX_IR_LEN-1:0]  ir_bits;
        dr_len_t                      dr_len;
        logic [`JTAG_MAX_DR_LEN-1:0]  dr_bits;
    } scan_request_t;

endpackage

//--- rtl/tap_step_if.sv
// Step signals shared by the three stages of the JTAG host.
// The TCK generator paces the sequencer and shifter, which trade state and last-bit.

`timescale 1ns/1ps

interface tap_step_if;

    // One-cycle strobes in the clk cycle before TCK changes level
    logic tck_rise;
    logic tck_fall;

    // Current TAP controller state
    jtag_tap_pkg::tap_state_t state;

    // High when exactly one bit remains in the current shift
    logic last_bit;

    modport clock_src
    (
        output tck_rise,
        output tck_fall
    );

    modport sequencer
    (
        input  tck_rise,
        input  tck_fall,
        input  last_bit,
        output state
    );

    modport shifter
    (
        input  tck_rise,
        input  tck_fall,
        input  state,
        output last_bit
    );

endinterface

//--- rtl/tck_generator.sv
// Divides clk down to a 50% duty TCK and flags each TCK edge one cycle early.
// The rest of the host runs on clk and acts on these strobes.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module tck_generator
(
    input  logic clk,
    input  logic reset,
    output logic tck,
    tap_step_if.clock_src step
);

    localparam int CNT_W = ($clog2(`JTAG_TCK_DIVISOR + 1) > 0)
        ? $clog2(`JTAG_TCK_DIVISOR + 1) : 1;
    localparam logic [CNT_W-1:0] DIV_LAST = CNT_W'(`JTAG_TCK_DIVISOR);

    logic [CNT_W-1:0] div_count;
    logic             tck_q;
    logic             toggle;

    assign toggle = (div_count == DIV_LAST);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_count <= '0;
            tck_q     <= 1'b0;
        end
        else if (toggle)
        begin
            div_count <= '0;
            tck_q     <= ~tck_q;
        end
        else
            div_count <= div_count + 1'b1;
    end

    // TCK goes high or low at the end of the cycle that sees the strobe
    assign step.tck_rise = toggle && !tck_q;
    assign step.tck_fall = toggle && tck_q;
    assign tck = tck_q;

endmodule

//--- rtl/tap_sequencer.sv
// Takes one scan request at a time and walks the TAP controller through it.
// TMS is set up on TCK falling edges and the state moves on TCK rising edges.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module tap_sequencer
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  jtag_host_pkg::ir_len_t        ir_len,
    input  logic [`JTAG_MAX_IR_LEN-1:0]   ir_value,
    input  jtag_host_pkg::dr_len_t        dr_len,
    input  logic [`JTAG_MAX_DR_LEN-1:0]   dr_value,
    output jtag_host_pkg::scan_request_t  request,
    output logic                          busy,
    output logic                          done,
    output logic                          tms,
    output logic                          trst_n,
    tap_step_if.sequencer                 step
);

    jtag_tap_pkg::tap_state_t state;
    jtag_tap_pkg::tap_state_t state_nxt;
    logic                     tms_nxt;
    logic                     need_ir;
    logic                     need_dr;

    // The request is held for the shifter until the next accepted start
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            request.ir_len  <= ir_len;
            request.ir_bits <= ir_value;
            request.dr_len  <= dr_len;
            request.dr_bits <= dr_value;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= jtag_tap_pkg::TAP_RESET;
            tms     <= 1'b1;
            busy    <= 1'b0;
            done    <= 1'b0;
            need_ir <= 1'b0;
            need_dr <= 1'b0;
        end
        else
        begin
            done <= step.tck_rise && state == jtag_tap_pkg::TAP_UPDATE_DR;

            if (start && !busy)
                busy <= 1'b1;

            if (step.tck_fall)
                tms <= tms_nxt;

            if (step.tck_rise)
            begin
                state <= state_nxt;

                // Arming on an Idle rise keeps TMS low for that rise, so the
                // walk always begins with one Idle step after start
                if (busy && state == jtag_tap_pkg::TAP_IDLE)
                begin
                    need_ir <= 1'b1;
                    need_dr <= 1'b1;
                end

                if (state == jtag_tap_pkg::TAP_UPDATE_IR)
                    need_ir <= 1'b0;

                if (state == jtag_tap_pkg::TAP_UPDATE_DR)
                begin
                    need_dr <= 1'b0;
                    busy    <= 1'b0;
                end
            end
        end
    end

    // Shortest legal path: IR scan first, then DR scan, then back to Idle
    always_comb
    begin
        state_nxt = state;
        tms_nxt   = 1'b0;
        case (state)
            jtag_tap_pkg::TAP_RESET:
                state_nxt = jtag_tap_pkg::TAP_IDLE;
            jtag_tap_pkg::TAP_IDLE:
            begin
                if (need_ir || need_dr)
                begin
                    state_nxt = jtag_tap_pkg::TAP_SELECT_DR;
                    tms_nxt   = 1'b1;
                end
            end
            jtag_tap_pkg::TAP_SELECT_DR:
            begin
                if (need_ir)
                begin
                    state_nxt = jtag_tap_pkg::TAP_SELECT_IR;
                    tms_nxt   = 1'b1;
                end
                else
                    state_nxt = jtag_tap_pkg::TAP_CAPTURE_DR;
            end
            jtag_tap_pkg::TAP_CAPTURE_DR:
                state_nxt = jtag_tap_pkg::TAP_SHIFT_DR;
            jtag_tap_pkg::TAP_SHIFT_DR:
            begin
                if (step.last_bit)
                begin
                    state_nxt = jtag_tap_pkg::TAP_EXIT1_DR;
                    tms_nxt   = 1'b1;
                end
            end
            jtag_tap_pkg::TAP_EXIT1_DR,
            jtag_tap_pkg::TAP_EXIT2_DR:
            begin
                state_nxt = jtag_tap_pkg::TAP_UPDATE_DR;
                tms_nxt   = 1'b1;
            end
            jtag_tap_pkg::TAP_PAUSE_DR:
            begin
                state_nxt = jtag_tap_pkg::TAP_EXIT2_DR;
                tms_nxt   = 1'b1;
            end
            jtag_tap_pkg::TAP_UPDATE_DR:
                state_nxt = jtag_tap_pkg::TAP_IDLE;
            jtag_tap_pkg::TAP_SELECT_IR:
                state_nxt = jtag_tap_pkg::TAP_CAPTURE_IR;
            jtag_tap_pkg::TAP_CAPTURE_IR:
                state_nxt = jtag_tap_pkg::TAP_SHIFT_IR;
            jtag_tap_pkg::TAP_SHIFT_IR:
            begin
                if (step.last_bit)
                begin
                    state_nxt = jtag_tap_pkg::TAP_EXIT1_IR;
                    tms_nxt   = 1'b1;
                end
            end
            jtag_tap_pkg::TAP_EXIT1_IR,
            jtag_tap_pkg::TAP_EXIT2_IR:
            begin
                state_nxt = jtag_tap_pkg::TAP_UPDATE_IR;
                tms_nxt   = 1'b1;
            end
            jtag_tap_pkg::TAP_PAUSE_IR:
            begin
                state_nxt = jtag_tap_pkg::TAP_EXIT2_IR;
                tms_nxt   = 1'b1;
            end
            jtag_tap_pkg::TAP_UPDATE_IR:
            begin
                if (need_dr)
                begin
                    state_nxt = jtag_tap_pkg::TAP_SELECT_DR;
                    tms_nxt   = 1'b1;
                end
                else
                    state_nxt = jtag_tap_pkg::TAP_IDLE;
            end
            default:
            begin
                state_nxt = jtag_tap_pkg::TAP_RESET;
                tms_nxt   = 1'b1;
            end
        endcase
    end

    // The target is held in reset while the host sits in Test-Logic-Reset
    assign trst_n = (state != jtag_tap_pkg::TAP_RESET);
    assign step.state = state;

endmodule

//--- rtl/scan_shifter.sv
// Shifts the IR and DR bits of a request out on TDI and collects TDO.
// One shift register serves both scans; the results are kept per register.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module scan_shifter
(
    input  logic                          clk,
    input  logic                          reset,
    input  jtag_host_pkg::scan_request_t  request,
    input  logic                          tdo,
    output logic                          tdi,
    output logic [`JTAG_MAX_IR_LEN-1:0]   ir_captured,
    output logic [`JTAG_MAX_DR_LEN-1:0]   dr_captured,
    tap_step_if.shifter                   step
);

    localparam int IR_W = `JTAG_MAX_IR_LEN;
    localparam int DR_W = `JTAG_MAX_DR_LEN;

    logic [DR_W-1:0]         shift_reg;
    logic [DR_W-1:0]         ir_load;
    logic [DR_W-1:0]         dr_load;
    jtag_host_pkg::dr_len_t  remaining;
    jtag_host_pkg::dr_len_t  cur_len;

    // Bits above the length are cleared so they read back as zero
    assign ir_load = DR_W'(request.ir_bits & ({IR_W{1'b1}} >> (IR_W - request.ir_len)));
    assign dr_load = request.dr_bits & ({DR_W{1'b1}} >> (DR_W - request.dr_len));

    assign cur_len = (step.state == jtag_tap_pkg::TAP_SHIFT_IR)
        ? jtag_host_pkg::dr_len_t'(request.ir_len) : request.dr_len;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            remaining <= '0;
        else if (step.tck_rise)
        begin
            case (step.state)
                jtag_tap_pkg::TAP_CAPTURE_IR:
                    remaining <= jtag_host_pkg::dr_len_t'(request.ir_len);
                jtag_tap_pkg::TAP_CAPTURE_DR:
                    remaining <= request.dr_len;
                jtag_tap_pkg::TAP_SHIFT_IR,
                jtag_tap_pkg::TAP_SHIFT_DR:
                    remaining <= remaining - 1'b1;
                default:
                    remaining <= remaining;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (step.tck_rise)
        begin
            case (step.state)
                jtag_tap_pkg::TAP_CAPTURE_IR:
                    shift_reg <= ir_load;
                jtag_tap_pkg::TAP_CAPTURE_DR:
                    shift_reg <= dr_load;
                // TDO enters at the top of the active length, LSB first
                jtag_tap_pkg::TAP_SHIFT_IR,
                jtag_tap_pkg::TAP_SHIFT_DR:
                    shift_reg <= (shift_reg >> 1) | (DR_W'(tdo) << (cur_len - 1));
                jtag_tap_pkg::TAP_EXIT1_IR:
                    ir_captured <= shift_reg[IR_W-1:0];
                jtag_tap_pkg::TAP_EXIT1_DR:
                    dr_captured <= shift_reg;
                default:
                    shift_reg <= shift_reg;
            endcase
        end
    end

    // TDI changes on the falling edge so it is stable at the next rise
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            tdi <= 1'b0;
        else if (step.tck_fall)
            tdi <= shift_reg[0];
    end

    assign step.last_bit = (remaining == 7'd1);

endmodule

//--- rtl/jtag_host.sv
// JTAG host top level. A start strobe runs one IR scan and one DR scan
// on the TAP pins and returns the captured bits with a done pulse.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module jtag_host
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  jtag_host_pkg::ir_len_t       ir_len,
    input  logic [`JTAG_MAX_IR_LEN-1:0]  ir_value,
    input  jtag_host_pkg::dr_len_t       dr_len,
    input  logic [`JTAG_MAX_DR_LEN-1:0]  dr_value,
    output logic                         busy,
    output logic                         done,
    output logic [`JTAG_MAX_IR_LEN-1:0]  ir_captured,
    output logic [`JTAG_MAX_DR_LEN-1:0]  dr_captured,
    output logic                         tck,
    output logic                         tms,
    output logic                         tdi,
    output logic                         trst_n,
    input  logic                         tdo
);

    jtag_host_pkg::scan_request_t request;

    tap_step_if step_if();

    tck_generator i_tck_generator
    (
        .clk    (clk),
        .reset  (reset),
        .tck    (tck),
        .step   (step_if.clock_src)
    );

    tap_sequencer i_tap_sequencer
    (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .ir_len   (ir_len),
        .ir_value (ir_value),
        .dr_len   (dr_len),
        .dr_value (dr_value),
        .request  (request),
        .busy     (busy),
        .done     (done),
        .tms      (tms),
        .trst_n   (trst_n),
        .step     (step_if.sequencer)
    );

    scan_shifter i_scan_shifter
    (
        .clk         (clk),
        .reset       (reset),
        .request     (request),
        .tdo         (tdo),
        .tdi         (tdi),
        .ir_captured (ir_captured),
        .dr_captured (dr_captured),
        .step        (step_if.shifter)
    );

endmodule

//--- testbench/jtag_target_model.sv
// Behavioral JTAG target for the host testbench.
// Follows TMS on TCK rises and sends the last updated IR and DR back out on TDO.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module jtag_target_model
(
    input  logic tck,
    input  logic tms,
    input  logic tdi,
    input  logic trst_n,
    output logic tdo
);

    localparam int IR_W = `JTAG_MAX_IR_LEN;
    localparam int DR_W = `JTAG_MAX_DR_LEN;

    jtag_tap_pkg::tap_state_t state;
    logic [IR_W-1:0]          ir_shift;
    logic [IR_W-1:0]          ir_updated;
    logic [DR_W-1:0]          dr_shift;
    logic [DR_W-1:0]          dr_updated;
    int                       shift_count;

    // IEEE 1149.1 state diagram
    function automatic jtag_tap_pkg::tap_state_t next_state
    (
        input jtag_tap_pkg::tap_state_t cur,
        input logic                     m
    );
        case (cur)
            jtag_tap_pkg::TAP_RESET:
                next_state = m ? jtag_tap_pkg::TAP_RESET : jtag_tap_pkg::TAP_IDLE;
            jtag_tap_pkg::TAP_IDLE:
                next_state = m ? jtag_tap_pkg::TAP_SELECT_DR : jtag_tap_pkg::TAP_IDLE;
            jtag_tap_pkg::TAP_SELECT_DR:
                next_state = m ? jtag_tap_pkg::TAP_SELECT_IR : jtag_tap_pkg::TAP_CAPTURE_DR;
            jtag_tap_pkg::TAP_CAPTURE_DR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT1_DR : jtag_tap_pkg::TAP_SHIFT_DR;
            jtag_tap_pkg::TAP_SHIFT_DR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT1_DR : jtag_tap_pkg::TAP_SHIFT_DR;
            jtag_tap_pkg::TAP_EXIT1_DR:
                next_state = m ? jtag_tap_pkg::TAP_UPDATE_DR : jtag_tap_pkg::TAP_PAUSE_DR;
            jtag_tap_pkg::TAP_PAUSE_DR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT2_DR : jtag_tap_pkg::TAP_PAUSE_DR;
            jtag_tap_pkg::TAP_EXIT2_DR:
                next_state = m ? jtag_tap_pkg::TAP_UPDATE_DR : jtag_tap_pkg::TAP_SHIFT_DR;
            jtag_tap_pkg::TAP_UPDATE_DR:
                next_state = m ? jtag_tap_pkg::TAP_SELECT_DR : jtag_tap_pkg::TAP_IDLE;
            jtag_tap_pkg::TAP_SELECT_IR:
                next_state = m ? jtag_tap_pkg::TAP_RESET : jtag_tap_pkg::TAP_CAPTURE_IR;
            jtag_tap_pkg::TAP_CAPTURE_IR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT1_IR : jtag_tap_pkg::TAP_SHIFT_IR;
            jtag_tap_pkg::TAP_SHIFT_IR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT1_IR : jtag_tap_pkg::TAP_SHIFT_IR;
            jtag_tap_pkg::TAP_EXIT1_IR:
                next_state = m ? jtag_tap_pkg::TAP_UPDATE_IR : jtag_tap_pkg::TAP_PAUSE_IR;
            jtag_tap_pkg::TAP_PAUSE_IR:
                next_state = m ? jtag_tap_pkg::TAP_EXIT2_IR : jtag_tap_pkg::TAP_PAUSE_IR;
            jtag_tap_pkg::TAP_EXIT2_IR:
                next_state = m ? jtag_tap_pkg::TAP_UPDATE_IR : jtag_tap_pkg::TAP_SHIFT_IR;
            default:
                next_state = m ? jtag_tap_pkg::TAP_SELECT_DR : jtag_tap_pkg::TAP_IDLE;
        endcase
    endfunction

    // Capture, shift and update act on the rise that leaves the state
    always_ff @(posedge tck or negedge trst_n)
    begin
        if (!trst_n)
        begin
            state       <= jtag_tap_pkg::TAP_RESET;
            ir_updated  <= '0;
            dr_updated  <= '0;
            shift_count <= 0;
        end
        else
        begin
            case (state)
                jtag_tap_pkg::TAP_CAPTURE_IR:
                begin
                    ir_shift    <= ir_updated;
                    shift_count <= 0;
                end
                jtag_tap_pkg::TAP_SHIFT_IR:
                begin
                    ir_shift    <= {tdi, ir_shift[IR_W-1:1]};
                    shift_count <= shift_count + 1;
                end
                // The shifted bits sit at the top of the register
                jtag_tap_pkg::TAP_UPDATE_IR:
                    ir_updated <= ir_shift >> (IR_W - shift_count);
                jtag_tap_pkg::TAP_CAPTURE_DR:
                begin
                    dr_shift    <= dr_updated;
                    shift_count <= 0;
                end
                jtag_tap_pkg::TAP_SHIFT_DR:
                begin
                    dr_shift    <= {tdi, dr_shift[DR_W-1:1]};
                    shift_count <= shift_count + 1;
                end
                jtag_tap_pkg::TAP_UPDATE_DR:
                    dr_updated <= dr_shift >> (DR_W - shift_count);
                default:
                    shift_count <= shift_count;
            endcase
            state <= next_state(state, tms);
        end
    end

    // TDO changes on the falling edge, LSB first
    always_ff @(negedge tck or negedge trst_n)
    begin
        if (!trst_n)
            tdo <= 1'b0;
        else if (state == jtag_tap_pkg::TAP_SHIFT_IR)
            tdo <= ir_shift[0];
        else if (state == jtag_tap_pkg::TAP_SHIFT_DR)
            tdo <= dr_shift[0];
    end

endmodule

//--- testbench/tb_jtag_host.sv
// Testbench for the JTAG host. Sends random scan requests to a loopback target
// and checks the handshake, the TCK and TMS timing and the captured bits.

`timescale 1ns/1ps

`include "jtag_consts.svh"

module tb_jtag_host;

    localparam int IR_W         = `JTAG_MAX_IR_LEN;
    localparam int DR_W         = `JTAG_MAX_DR_LEN;
    localparam int HALF_PERIOD  = `JTAG_TCK_DIVISOR + 1;
    localparam int NUM_TRANS    = 20;
    localparam int SEED         = 87499;
    localparam int RESET_CYCLES = 10;
    localparam int WALK_EXTRA   = 11;
    // Every transaction at the longest walk, plus room for reset and gaps
    localparam int CYCLE_LIMIT  =
        NUM_TRANS * (IR_W + DR_W + WALK_EXTRA) * 2 * HALF_PERIOD + 5760;

    logic                   clk;
    logic                   reset;
    logic                   start;
    jtag_host_pkg::ir_len_t ir_len;
    logic [IR_W-1:0]        ir_value;
    jtag_host_pkg::dr_len_t dr_len;
    logic [DR_W-1:0]        dr_value;
    logic                   busy;
    logic                   done;
    logic [IR_W-1:0]        ir_captured;
    logic [DR_W-1:0]        dr_captured;
    logic                   tck;
    logic                   tms;
    logic                   tdi;
    logic                   trst_n;
    logic                   tdo;

    int                     error_count;
    int                     accepted_count;
    int                     done_count;
    int                     ignored_count;
    int                     pulses_sent;
    int                     cycle_count;
    int                     rise_count;
    int                     gap_count;
    int                     reset_count;
    logic                   counting;
    logic                   seen_rise;
    logic                   accept_prev;
    logic                   tck_d;
    logic                   tms_d;
    logic                   done_d;
    jtag_host_pkg::ir_len_t exp_ir_len;
    jtag_host_pkg::dr_len_t exp_dr_len;
    logic [IR_W-1:0]        exp_ir_value;
    logic [DR_W-1:0]        exp_dr_value;
    logic [IR_W-1:0]        prev_ir;
    logic [DR_W-1:0]        prev_dr;
    logic [IR_W-1:0]        want_ir;
    logic [DR_W-1:0]        want_dr;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    jtag_host i_jtag_host
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .ir_len      (ir_len),
        .ir_value    (ir_value),
        .dr_len      (dr_len),
        .dr_value    (dr_value),
        .busy        (busy),
        .done        (done),
        .ir_captured (ir_captured),
        .dr_captured (dr_captured),
        .tck         (tck),
        .tms         (tms),
        .tdi         (tdi),
        .trst_n      (trst_n),
        .tdo         (tdo)
    );

    jtag_target_model i_jtag_target_model
    (
        .tck    (tck),
        .tms    (tms),
        .tdi    (tdi),
        .trst_n (trst_n),
        .tdo    (tdo)
    );

    // Ones in the low len bits
    function automatic logic [DR_W-1:0] low_mask(input int len);
        if (len >= DR_W)
            low_mask = {DR_W{1'b1}};
        else
            low_mask = (DR_W'(1) << len) - 1'b1;
    endfunction

    task automatic report_mismatch
    (
        input string           test_name,
        input logic [DR_W-1:0] expected,
        input logic [DR_W-1:0] actual
    );
        error_count++;
        $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Samples at posedge see the values that held through the last cycle
    always @(posedge clk)
    begin
        if (reset)
        begin
            reset_count++;
            gap_count = 0;
            counting  = 1'b0;
            if (reset_count > 1)
                assert (!busy && !done && tms && !trst_n && !tck)
                else report_failure("outputs differ from their reset values");
        end
        else
        begin
            gap_count++;
            if (tck != tck_d)
            begin
                assert (gap_count >= HALF_PERIOD)
                else report_failure($sformatf("TCK changed after %0d clk cycles", gap_count));
                gap_count = 0;
            end
            if (tms != tms_d)
                assert (tck_d && !tck)
                else report_failure("TMS changed without a TCK falling edge");
            if (!seen_rise && !tck)
                assert (!trst_n) else report_failure("TRST_N released before the first TCK rise");
            if (tck && !tck_d)
            begin
                if (!seen_rise)
                    assert (trst_n) else report_failure("TRST_N still low after the first rise");
                seen_rise = 1'b1;
                if (counting)
                    rise_count++;
            end
            // The finished request is checked before a start in the same cycle replaces it
            if (done)
            begin
                done_count++;
                assert (counting) else report_failure("done pulsed without an accepted start");
                assert (!done_d) else report_failure("done stayed high for two cycles");
                assert (rise_count == exp_ir_len + exp_dr_len + WALK_EXTRA)
                else report_mismatch("tck_rises", 64'(exp_ir_len + exp_dr_len + WALK_EXTRA),
                    64'(rise_count));
                // The target returns what the previous request left in it
                want_ir = prev_ir & IR_W'(low_mask(int'(exp_ir_len)));
                want_dr = prev_dr & low_mask(int'(exp_dr_len));
                assert (ir_captured == want_ir)
                else report_mismatch("ir_capture", 64'(want_ir), 64'(ir_captured));
                assert (dr_captured == want_dr)
                else report_mismatch("dr_capture", want_dr, dr_captured);
                prev_ir  = exp_ir_value & IR_W'(low_mask(int'(exp_ir_len)));
                prev_dr  = exp_dr_value & low_mask(int'(exp_dr_len));
                counting = 1'b0;
            end
            // A rise on the accepting edge still belongs to the idle host
            if (accept_prev)
            begin
                counting   = 1'b1;
                rise_count = 0;
            end
            accept_prev = start && !busy;
            if (start && !busy)
            begin
                accepted_count++;
                exp_ir_len   = ir_len;
                exp_dr_len   = dr_len;
                exp_ir_value = ir_value;
                exp_dr_value = dr_value;
            end
            else if (start)
                ignored_count++;
        end
        tck_d  = tck;
        tms_d  = tms;
        done_d = done;
    end

    task automatic run_transaction(input int index);
        int ir_n;
        int dr_n;
        int wait_cycles;
        if (index == 1)
        begin
            ir_n = 1;
            dr_n = 1;
        end
        else if (index == 2)
        begin
            ir_n = IR_W;
            dr_n = DR_W;
        end
        else
        begin
            ir_n = $urandom_range(IR_W, 1);
            dr_n = $urandom_range(DR_W, 1);
        end
        while (busy)
            @(negedge clk);
        ir_len   = jtag_host_pkg::ir_len_t'(ir_n);
        dr_len   = jtag_host_pkg::dr_len_t'(dr_n);
        ir_value = $urandom;
        dr_value = {$urandom, $urandom};
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // Every third request gets a second start in the middle of its scan
        if (index % 3 == 2)
        begin
            wait_cycles = $urandom_range(40, 2);
            repeat (wait_cycles) @(negedge clk);
            ir_len   = jtag_host_pkg::ir_len_t'($urandom_range(IR_W, 1));
            dr_len   = jtag_host_pkg::dr_len_t'($urandom_range(DR_W, 1));
            ir_value = $urandom;
            dr_value = {$urandom, $urandom};
            start    = 1'b1;
            pulses_sent++;
            @(negedge clk);
            start = 1'b0;
        end
        do
            @(negedge clk);
        while (!done);
        wait_cycles = $urandom_range(5, 0);
        repeat (wait_cycles) @(negedge clk);
    endtask

    initial
    begin
        void'($urandom(SEED));
        error_count    = 0;
        accepted_count = 0;
        done_count     = 0;
        ignored_count  = 0;
        pulses_sent    = 0;
        rise_count     = 0;
        gap_count      = 0;
        reset_count    = 0;
        counting       = 1'b0;
        seen_rise      = 1'b0;
        accept_prev    = 1'b0;
        tck_d          = 1'b0;
        tms_d          = 1'b1;
        done_d         = 1'b0;
        prev_ir        = '0;
        prev_dr        = '0;
        reset          = 1'b1;
        start          = 1'b0;
        ir_len         = '0;
        ir_value       = '0;
        dr_len         = '0;
        dr_value       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        while (!trst_n)
            @(negedge clk);
        for (int idx = 0; idx < NUM_TRANS; idx++)
            run_transaction(idx);
        @(negedge clk);
        assert (accepted_count == NUM_TRANS && done_count == accepted_count)
        else report_failure("done pulses do not match the accepted starts");
        assert (ignored_count == pulses_sent)
        else report_failure("a start pulsed while busy was not ignored");
        $display("Summary: %0d accepted, %0d done, %0d ignored starts, %0d errors",
            accepted_count, done_count, ignored_count, error_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d clk cycles with %0d of %0d transactions done",
            cycle_count, done_count, NUM_TRANS);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- jtag_host.f
+incdir+rtl
rtl/jtag_tap_pkg.sv
rtl/jtag_host_pkg.sv
rtl/tap_step_if.sv
rtl/tck_generator.sv
rtl/tap_sequencer.sv
rtl/scan_shifter.sv
rtl/jtag_host.sv
testbench/jtag_target_model.sv
testbench/tb_jtag_host.sv
